//--- design/aluPkg.sv
/*
 * Byte-serial ALU shared types
 * Widths, opcodes, command and flag layouts, sequencer states
 */
`default_nettype none

package aluPkg;

  // Host byte and register word
  typedef logic [7:0]  byteT;
  typedef logic [15:0] wordT;

  typedef enum logic [1:0] {
    opLoad = 2'd0,
    opAdd  = 2'd1,
    opSub  = 2'd2,
    opMul  = 2'd3
  } opT;

  // Command word as presented by the host
  typedef struct packed {
    opT   op;
    logic regSel;   // 0 = A, 1 = B
    logic byteSel;  // 0 = low, 1 = high
    logic write;    // opLoad only, 0 sets read select
    logic useA;     // add/sub operand is A instead of the byte
  } cmdT;

  typedef struct packed {
    logic carry;
    logic borrow;
  } flagsT;

  typedef enum logic [1:0] {
    sIdle    = 2'd0,
    sExec    = 2'd1,
    sMulStep = 2'd2,
    sDone    = 2'd3
  } seqStateT;

endpackage

`default_nettype wire

//--- design/inputSync.sv
/*
 * Input synchroniser
 * Registers host data, command and start, and turns a rising start into a one-clock request
 */
`timescale 1ns/100ps
`default_nettype none

module inputSync import aluPkg::*; (
  input  wire  CLK,
  input  wire  RST,
  input  byteT dataIn,
  input  cmdT  cmd,
  input  wire  start,
  output byteT syncData,
  output cmdT  syncCmd,
  output logic startReq
);

  logic syncStart;
  logic prevStart;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      syncData  <= '0;
      syncCmd   <= '0;
      syncStart <= 1'b0;
      prevStart <= 1'b0;
      startReq  <= 1'b0;
    end
    else
    begin
      // First stage
      syncData  <= dataIn;
      syncCmd   <= cmd;
      syncStart <= start;
      // Second stage, edge pulse
      prevStart <= syncStart;
      startReq  <= syncStart & ~prevStart;
    end
  end

endmodule

`default_nettype wire

//--- design/opSequencer.sv
/*
 * Command sequencer
 * Accepts start requests, latches the command and issues register strobes
 * Multiply runs MulSteps steps, one operand bit per clock
 */
`timescale 1ns/100ps
`default_nettype none

module opSequencer import aluPkg::*; #(
  parameter int MulSteps = 8
) (
  input  wire  CLK,
  input  wire  RST,
  input  cmdT  syncCmd,
  input  byteT syncData,
  input  wire  startReq,
  output cmdT  curCmd,
  output byteT opByte,
  output logic loadEn,
  output logic selEn,
  output logic wordEn,
  output logic mulInit,
  output logic mulStep,
  output logic busy,
  output logic done
);

  localparam int CntW = (MulSteps > 1) ? $clog2(MulSteps) : 1;
  localparam logic [CntW-1:0] LastStep = CntW'(MulSteps - 1);

  seqStateT        state;
  logic [CntW-1:0] stepCnt;

  ////////////////////////////////////////////////////////////////////////////
  // State and latched command
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      state   <= sIdle;
      curCmd  <= '0;
      opByte  <= '0;
      stepCnt <= '0;
    end
    else
    begin
      case (state)
        sIdle, sDone:
        begin
          if (startReq)
          begin
            state   <= sExec;
            curCmd  <= syncCmd;
            opByte  <= syncData;
            stepCnt <= '0;
          end
        end
        sExec:
          state <= (curCmd.op == opMul) ? sMulStep : sDone;
        sMulStep:
        begin
          // Next multiplier bit moves down to bit 0
          opByte <= opByte >> 1;
          if (stepCnt == LastStep)
            state <= sDone;
          else
            stepCnt <= stepCnt + 1'b1;
        end
        default:
          state <= sIdle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobes, one per executed cycle
  always_comb
  begin
    loadEn  = 1'b0;
    selEn   = 1'b0;
    wordEn  = 1'b0;
    mulInit = 1'b0;
    if (state == sExec)
    begin
      case (curCmd.op)
        opLoad:
        begin
          if (curCmd.write)
            loadEn = 1'b1;
          else
            selEn = 1'b1;
        end
        opAdd:   wordEn = 1'b1;
        opSub:   wordEn = 1'b1;
        default: mulInit = 1'b1;
      endcase
    end
  end

  assign mulStep = (state == sMulStep);
  assign busy    = (state == sExec) || (state == sMulStep);
  assign done    = (state == sDone);

endmodule

`default_nettype wire

//--- design/operandRegs.sv
/*
 * Operand registers
 * Holds A, B, the multiply shift copy and the read select, and drives the output byte
 */
`timescale 1ns/100ps
`default_nettype none

module operandRegs import aluPkg::*; (
  input  wire  CLK,
  input  wire  RST,
  input  cmdT  curCmd,
  input  byteT opByte,
  input  wordT sum,
  input  wire  loadEn,
  input  wire  selEn,
  input  wire  wordEn,
  input  wire  mulInit,
  input  wire  mulStep,
  output wordT regA,
  output wordT regB,
  output wordT mulShift,
  output byteT dataOut
);

  // {regSel, byteSel} of the last read-select command
  logic [1:0] readSel;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regA     <= '0;
      regB     <= '0;
      mulShift <= '0;
      readSel  <= 2'b00;
    end
    else
    begin
      if (loadEn)
      begin
        case ({curCmd.regSel, curCmd.byteSel})
          2'b00:   regA[7:0]  <= opByte;
          2'b01:   regA[15:8] <= opByte;
          2'b10:   regB[7:0]  <= opByte;
          default: regB[15:8] <= opByte;
        endcase
      end
      if (selEn)
        readSel <= {curCmd.regSel, curCmd.byteSel};
      // Add, sub and multiply steps all take the adder result
      if (wordEn || mulStep)
        regB <= sum;
      if (mulInit)
      begin
        regB     <= '0;
        mulShift <= regA;
      end
      else if (mulStep)
        mulShift <= {mulShift[14:0], 1'b0};
    end
  end

  // Output byte mux
  always_comb
  begin
    case (readSel)
      2'b00:   dataOut = regA[7:0];
      2'b01:   dataOut = regA[15:8];
      2'b10:   dataOut = regB[7:0];
      default: dataOut = regB[15:8];
    endcase
  end

endmodule

`default_nettype wire

//--- design/arithUnit.sv
/*
 * Arithmetic unit
 * Adds to or subtracts from B, accumulates multiply partial products, keeps the flags
 */
`timescale 1ns/100ps
`default_nettype none

module arithUnit import aluPkg::*; (
  input  wire   CLK,
  input  wire   RST,
  input  cmdT   curCmd,
  input  byteT  opByte,
  input  wordT  regA,
  input  wordT  regB,
  input  wordT  mulShift,
  input  wire   wordEn,
  input  wire   mulInit,
  input  wire   bitTake,
  output wordT  sum,
  output flagsT flags
);

  wordT        operand;
  logic [16:0] result;

  // Operand source for add and sub
  assign operand = curCmd.useA ? regA : {8'h00, opByte};

  always_comb
  begin
    case (curCmd.op)
      opSub:   result = {1'b0, regB} - {1'b0, operand};
      opMul:   result = {1'b0, regB} + {1'b0, (bitTake ? mulShift : 16'h0000)};
      default: result = {1'b0, regB} + {1'b0, operand};
    endcase
  end

  assign sum = result[15:0];

  // Bit 16 is carry-out on add, borrow on sub
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      flags <= '0;
    else if (mulInit)
      flags <= '0;
    else if (wordEn)
    begin
      if (curCmd.op == opSub)
        flags.borrow <= result[16];
      else
        flags.carry <= result[16];
    end
  end

endmodule

`default_nettype wire

//--- design/byteAlu.sv
/*
 * Byte-serial arithmetic unit, top level
 * Two 16-bit operand registers with byte load and read-back, add, sub and multiply
 */
`timescale 1ns/100ps
`default_nettype none

module byteAlu import aluPkg::*; #(
  parameter int MulSteps = 8
) (
  input  wire   CLK,
  input  wire   RST,
  input  byteT  dataIn,
  input  cmdT   cmd,
  input  wire   start,
  output byteT  dataOut,
  output flagsT flags,
  output logic  busy,
  output logic  done
);

  byteT syncData;
  byteT opByte;
  cmdT  syncCmd;
  cmdT  curCmd;
  wordT regA;
  wordT regB;
  wordT mulShift;
  wordT sum;
  logic startReq;
  logic loadEn;
  logic selEn;
  logic wordEn;
  logic mulInit;
  logic mulStep;

  inputSync uSync (
    .CLK      (CLK),
    .RST      (RST),
    .dataIn   (dataIn),
    .cmd      (cmd),
    .start    (start),
    .syncData (syncData),
    .syncCmd  (syncCmd),
    .startReq (startReq)
  );

  opSequencer #(
    .MulSteps (MulSteps)
  ) uSeq (
    .CLK      (CLK),
    .RST      (RST),
    .syncCmd  (syncCmd),
    .syncData (syncData),
    .startReq (startReq),
    .curCmd   (curCmd),
    .opByte   (opByte),
    .loadEn   (loadEn),
    .selEn    (selEn),
    .wordEn   (wordEn),
    .mulInit  (mulInit),
    .mulStep  (mulStep),
    .busy     (busy),
    .done     (done)
  );

  operandRegs uRegs (
    .CLK      (CLK),
    .RST      (RST),
    .curCmd   (curCmd),
    .opByte   (opByte),
    .sum      (sum),
    .loadEn   (loadEn),
    .selEn    (selEn),
    .wordEn   (wordEn),
    .mulInit  (mulInit),
    .mulStep  (mulStep),
    .regA     (regA),
    .regB     (regB),
    .mulShift (mulShift),
    .dataOut  (dataOut)
  );

  // Current multiplier bit sits in bit 0 during a step
  arithUnit uArith (
    .CLK      (CLK),
    .RST      (RST),
    .curCmd   (curCmd),
    .opByte   (opByte),
    .regA     (regA),
    .regB     (regB),
    .mulShift (mulShift),
    .wordEn   (wordEn),
    .mulInit  (mulInit),
    .bitTake  (mulStep & opByte[0]),
    .sum      (sum),
    .flags    (flags)
  );

endmodule

`default_nettype wire

//--- test/byteAlu_checker.sv
/*
 * Control-output assertions for the byte-serial ALU, bound to the top level
 */
`timescale 1ns/100ps
`default_nettype none

module byteAlu_checker #(
  parameter int MulSteps = 8
) (
  input wire CLK,
  input wire RST,
  input wire busy,
  input wire done
);

  // Busy cycles seen before the current one
  int busyLen;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      busyLen <= 0;
    else if (busy)
      busyLen <= busyLen + 1;
    else
      busyLen <= 0;
  end

  busyDoneExclusive: assert property (@(posedge CLK) disable iff (!RST)
    !(busy && done))
    else $error("busy and done high in the same cycle");

  doneEndsBusy: assert property (@(posedge CLK) disable iff (!RST)
    $rose(done) |-> $fell(busy))
    else $error("done rose without busy falling");

  // Longest command is a multiply, MulSteps plus the exec cycle
  busyBounded: assert property (@(posedge CLK) disable iff (!RST)
    busy |-> busyLen <= MulSteps)
    else $error("busy held longer than MulSteps plus one clocks");

endmodule

bind byteAlu byteAlu_checker #(.MulSteps(MulSteps)) uChecker (
  .CLK  (CLK),
  .RST  (RST),
  .busy (busy),
  .done (done)
);

`default_nettype wire

//--- test/tbByteAlu.sv
/*
 * Testbench for the byte-serial ALU
 * File-driven commands, a start while busy, then random traffic against a reference model
 */
`timescale 1ns/100ps
`default_nettype none

module tbByteAlu import aluPkg::*; ();

  localparam int Timeout   = 50;
  localparam int RandPairs = 20;

  logic  CLK;
  logic  RST;
  byteT  dataIn;
  cmdT   cmd;
  logic  start;
  byteT  dataOut;
  flagsT flags;
  logic  busy;
  logic  done;

  // Reference model state
  wordT  refA;
  wordT  refB;
  flagsT refFlags;

  int errors;
  int checks;
  int seed;

  byteAlu dut (
    .CLK     (CLK),
    .RST     (RST),
    .dataIn  (dataIn),
    .cmd     (cmd),
    .start   (start),
    .dataOut (dataOut),
    .flags   (flags),
    .busy    (busy),
    .done    (done)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  task automatic finishRun();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  task automatic abortRun(input string what);
    $display("Timeout at %0t, %s never went high", $time, what);
    errors++;
    finishRun();
  endtask

  task automatic checkValue(input string name, input logic [15:0] expVal,
                            input logic [15:0] gotVal);
    checks++;
    if (gotVal !== expVal)
    begin
      errors++;
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expVal, gotVal);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command helpers
  function automatic cmdT makeCmd(input opT op, input logic rs, input logic bs,
                                  input logic wr, input logic ua);
    cmdT c;
    c.op      = op;
    c.regSel  = rs;
    c.byteSel = bs;
    c.write   = wr;
    c.useA    = ua;
    return c;
  endfunction

  // Expected register and flag effect of one command
  function automatic void applyModel(input cmdT c, input byteT d);
    wordT opnd;
    int   total;
    opnd = c.useA ? refA : {8'h00, d};
    case (c.op)
      opLoad:
      begin
        if (c.write && !c.regSel && !c.byteSel) refA[7:0] = d;
        if (c.write && !c.regSel && c.byteSel)  refA[15:8] = d;
        if (c.write && c.regSel && !c.byteSel)  refB[7:0] = d;
        if (c.write && c.regSel && c.byteSel)   refB[15:8] = d;
      end
      opAdd:
      begin
        total = int'(refB) + int'(opnd);
        refFlags.carry = (total > 65535);
        refB = wordT'(total % 65536);
      end
      opSub:
      begin
        refFlags.borrow = (refB < opnd);
        refB = refB - opnd;
      end
      default:
      begin
        refB = refA * {8'h00, d};
        refFlags = '0;
      end
    endcase
  endfunction

  task automatic waitBusy();
    int cnt;
    cnt = 0;
    while (!busy && cnt < Timeout)
    begin
      @(negedge CLK);
      cnt++;
    end
    if (!busy)
      abortRun("busy");
  endtask

  task automatic waitDone();
    int cnt;
    cnt = 0;
    while (!done && cnt < Timeout)
    begin
      @(negedge CLK);
      cnt++;
    end
    if (!done)
      abortRun("done");
  endtask

  task automatic issueCmd(input cmdT c, input byteT d);
    @(negedge CLK);
    cmd    = c;
    dataIn = d;
    start  = 1'b1;
    @(negedge CLK);
    waitBusy();
    start = 1'b0;
    waitDone();
    applyModel(c, d);
  endtask

  task automatic readBack(input logic rs, input logic bs);
    wordT w;
    issueCmd(makeCmd(opLoad, rs, bs, 1'b0, 1'b0), 8'h00);
    w = rs ? refB : refA;
    checkValue("dataOut", {8'h00, (bs ? w[15:8] : w[7:0])}, {8'h00, dataOut});
  endtask

  // Second start edge during a multiply must be lost
  task automatic startWhileBusy();
    cmdT mulCmd;
    int  cnt;
    mulCmd = makeCmd(opMul, 1'b1, 1'b0, 1'b0, 1'b0);
    @(negedge CLK);
    cmd    = mulCmd;
    dataIn = 8'h05;
    start  = 1'b1;
    @(negedge CLK);
    waitBusy();
    start = 1'b0;
    @(negedge CLK);
    cmd    = makeCmd(opAdd, 1'b1, 1'b0, 1'b0, 1'b0);
    dataIn = 8'h77;
    start  = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    waitDone();
    applyModel(mulCmd, 8'h05);
    for (cnt = 0; cnt < 4; cnt++)
    begin
      @(negedge CLK);
      checks++;
      if (busy || !done)
      begin
        errors++;
        $display("Start edge during busy was accepted after the multiply at %0t", $time);
      end
    end
    readBack(1'b1, 1'b0);
    readBack(1'b1, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    int          fd;
    int          n;
    int          fOp, fRs, fBs, fWr, fUa, fData, fExp;
    string       line;
    cmdT         c;
    opT          rop;
    logic [31:0] r;
    CLK      = 1'b0;
    RST      = 1'b0;
    dataIn   = '0;
    cmd      = '0;
    start    = 1'b0;
    errors   = 0;
    checks   = 0;
    seed     = 32'h10961eff;
    refA     = '0;
    refB     = '0;
    refFlags = '0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    checkValue("busy", 16'h0, {15'h0, busy});
    checkValue("done", 16'h0, {15'h0, done});
    checkValue("flags", 16'h0, {14'h0, flags});

    fd = $fopen("test/test_input.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open test/test_input.txt for reading");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() == 0 || line[0] == "#")
          continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h", fOp, fRs, fBs, fWr, fUa, fData, fExp);
        if (n != 7)
          continue;
        c = makeCmd(opT'(fOp[1:0]), fRs[0], fBs[0], fWr[0], fUa[0]);
        issueCmd(c, fData[7:0]);
        if (c.op == opLoad && !c.write)
          checkValue("dataOut", {8'h00, fExp[7:0]}, {8'h00, dataOut});
        else if (c.op != opLoad)
          checkValue("flags", {14'h0, fExp[1:0]}, {14'h0, flags});
      end
      $fclose(fd);
    end

    startWhileBusy();

    for (int i = 0; i < RandPairs; i++)
    begin
      r = $random(seed);
      issueCmd(makeCmd(opLoad, 1'b0, r[8], 1'b1, 1'b0), r[7:0]);
      rop = r[9] ? opSub : opAdd;
      issueCmd(makeCmd(rop, 1'b1, 1'b0, 1'b0, r[10]), r[23:16]);
      checkValue("flags", {14'h0, refFlags}, {14'h0, flags});
      readBack(1'b1, 1'b1);
      issueCmd(makeCmd(opMul, 1'b1, 1'b0, 1'b0, 1'b0), r[31:24]);
      checkValue("flags", {14'h0, refFlags}, {14'h0, flags});
      readBack(1'b1, 1'b0);
      readBack(1'b1, 1'b1);
      readBack(1'b0, r[11]);
    end

    finishRun();
  end

endmodule

`default_nettype wire

//--- test/test_input.txt
# op(0 load, 1 add, 2 sub, 3 mul) regSel byteSel write useA data expected, all hex
# expected: byte read back for a read select, {carry,borrow} for add/sub/mul, unused for writes
0 0 0 0 0 00 00
0 0 1 0 0 00 00
0 1 0 0 0 00 00
0 1 1 0 0 00 00
0 0 0 1 0 34 00
0 0 1 1 0 12 00
0 1 0 1 0 f0 00
0 1 1 1 0 ff 00
0 0 1 0 0 00 12
0 1 0 0 0 00 f0
1 1 0 0 0 20 2
0 1 0 0 0 00 10
2 1 0 0 1 00 3
0 1 1 0 0 00 ed
2 1 0 0 0 10 2
3 1 0 0 0 0b 0
0 1 1 0 0 00 c8
0 0 0 0 0 00 34

//--- tb.f
design/aluPkg.sv
design/inputSync.sv
design/opSequencer.sv
design/operandRegs.sv
design/arithUnit.sv
design/byteAlu.sv
test/byteAlu_checker.sv
test/tbByteAlu.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tbByteAlu
FILELIST   = tb.f
LOG        = sim.log
FAIL_MSG   = tests failed
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
